//--- logic/da_host_pkg.sv
////////////////////////////////////////
// Host protocol definitions for the
// converter command core
////////////////////////////////////////

package da_host_pkg;

    localparam int HOST_WIDTH = 16;

    typedef logic [HOST_WIDTH-1:0] host_word_t;

    // Command codes carried in the second word of a frame
    typedef enum logic [7:0] {
        AUD_FIFO_WRITE = 8'h10,
        CMD_FIFO_WRITE = 8'h11,
        DIRCHAN_READ   = 8'h20,
        AOVF_READ      = 8'h21,
        SELECT_CLOCK   = 8'h30,
        ECHO_SEND      = 8'h40
    } cmd_e;

    // Report codes sent back to the host
    typedef enum logic [7:0] {
        DIRCHAN_REPORT = 8'h22,
        AOVF_REPORT    = 8'h23,
        ECHO_REPORT    = 8'h41,
        CHECKSUM_ERROR = 8'hE0
    } rpt_e;

    // Length is two words, high first, 24 bits taken from the low end
    localparam int LEN_WORDS = 2;
    localparam int CSUM_WORDS = 2;

    // Modulo 2^32 sum of the data words
    typedef logic [31:0] checksum_t;

    // Slot field of status replies
    localparam logic [7:0] GLOBAL_SLOT = 8'hFF;

endpackage

//--- logic/da_slot_pkg.sv
////////////////////////////////////////
// Converter slot definitions
////////////////////////////////////////

package da_slot_pkg;

    localparam int SAMPLE_WIDTH = 32;

    typedef logic [7:0] slot_idx_t;

    typedef logic [SAMPLE_WIDTH-1:0] sample_t;

    // One byte of direction/channel or overflow flags
    typedef logic [7:0] status_t;

    // Control protocol uses the low byte of a host word
    typedef logic [7:0] ctl_byte_t;

endpackage

//--- logic/da_sample_packer.sv
////////////////////////////////////////
// Sample packer
// Collects host words into 32-bit audio
// samples, first word in the high half
////////////////////////////////////////

`timescale 1ns/1ps

module da_sample_packer (
    input  logic                   cr_core,
    input  logic                   arst_n,
    input  logic                   pk_clear,
    input  logic                   pk_word,
    input  da_host_pkg::host_word_t pk_data,
    input  da_slot_pkg::slot_idx_t pk_slot,
    output logic                   sample_valid,
    output da_slot_pkg::sample_t   sample_data,
    output da_slot_pkg::slot_idx_t sample_slot
);
    import da_host_pkg::*;
    import da_slot_pkg::*;

    localparam int cnt_w = $clog2(SAMPLE_WIDTH) + 1;

    // Bits collected so far in the current sample
    logic [cnt_w-1:0] bit_cnt;

    always_ff @(posedge cr_core or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (pk_clear) begin
                // New write command, drop any unpaired word
                bit_cnt <= '0;
            end else if (pk_word) begin
                if (bit_cnt + cnt_w'(HOST_WIDTH) >= cnt_w'(SAMPLE_WIDTH)) begin
                    sample_valid <= 1'b1;
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + cnt_w'(HOST_WIDTH);
                end
            end
        end
    end

    always_ff @(posedge cr_core) begin
        if (pk_word) begin
            sample_data <= {sample_data[SAMPLE_WIDTH-HOST_WIDTH-1:0], pk_data};
            sample_slot <= pk_slot;
        end
    end

    a_clear_word_apart: assert property (@(posedge cr_core) disable iff (!arst_n)
        !(pk_clear && pk_word));

endmodule

//--- logic/da_echo_fifo.sv
////////////////////////////////////////
// Echo FIFO
// Show-ahead buffer for echo payload
////////////////////////////////////////

`timescale 1ns/1ps

module da_echo_fifo #(
    parameter int echo_log_depth = 4
) (
    input  logic                    cr_core,
    input  logic                    arst_n,
    input  logic                    wr_valid,
    input  da_host_pkg::host_word_t wr_data,
    input  logic                    rd_ready,
    output da_host_pkg::host_word_t rd_data,
    output logic                    empty
);
    import da_host_pkg::*;

    localparam int depth = 1 << echo_log_depth;

    host_word_t mem [depth];

    // Extra top bit tells full from empty
    logic [echo_log_depth:0] wr_ptr;
    logic [echo_log_depth:0] rd_ptr;
    logic                    full;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[echo_log_depth] != rd_ptr[echo_log_depth]) &&
                  (wr_ptr[echo_log_depth-1:0] == rd_ptr[echo_log_depth-1:0]);

    // Oldest word is always on the output
    assign rd_data = mem[rd_ptr[echo_log_depth-1:0]];

    always_ff @(posedge cr_core or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_ready)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge cr_core) begin
        if (wr_valid)
            mem[wr_ptr[echo_log_depth-1:0]] <= wr_data;
    end

    a_no_overflow: assert property (@(posedge cr_core) disable iff (!arst_n)
        wr_valid |-> !full);
    a_no_underflow: assert property (@(posedge cr_core) disable iff (!arst_n)
        rd_ready |-> !empty);

endmodule

//--- logic/da_cmd_parser.sv
////////////////////////////////////////
// Command parser, first pipeline stage
// Splits host frames into audio, control,
// echo and clock-select actions and
// requests replies
////////////////////////////////////////

`timescale 1ns/1ps

module da_cmd_parser #(
    parameter int num_slots = 4,
    parameter int echo_log_depth = 4
) (
    input  logic                    cr_core,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  da_host_pkg::host_word_t in_data,
    output logic                    pk_clear,
    output logic                    pk_word,
    output da_host_pkg::host_word_t pk_data,
    output da_slot_pkg::slot_idx_t  slot,
    output logic                    ctl_valid,
    output da_slot_pkg::ctl_byte_t  ctl_data,
    output logic                    echo_wr,
    output da_host_pkg::host_word_t echo_data,
    output logic [num_slots-1:0]    clksel,
    output logic [num_slots-1:0]    slot_restart,
    output logic                    rpt_start,
    output da_host_pkg::rpt_e       rpt_code,
    output da_slot_pkg::slot_idx_t  rpt_slot,
    output da_host_pkg::host_word_t rpt_count,
    output da_host_pkg::checksum_t  csum_received,
    output da_host_pkg::checksum_t  csum_calc
);
    import da_host_pkg::*;

    // Largest echo that fits the FIFO
    localparam host_word_t echo_max = host_word_t'((1 << echo_log_depth) - 1);

    typedef enum logic [1:0] {
        ST_SLOT,
        ST_CMD,
        ST_BODY,
        ST_CSUM
    } state_e;

    state_e      state;
    cmd_e        cmd;
    logic [23:0] length;
    // Position within the body or checksum words
    logic [24:0] word_cnt;
    host_word_t  data_q;

    // One data register feeds every payload path
    assign pk_data = data_q;
    assign echo_data = data_q;
    assign ctl_data = data_q[7:0];

    always_ff @(posedge cr_core) begin
        if (in_valid)
            data_q <= in_data;
    end

    always_ff @(posedge cr_core or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_SLOT;
            cmd <= AUD_FIFO_WRITE;
            slot <= '0;
            length <= '0;
            word_cnt <= '0;
            csum_calc <= '0;
            csum_received <= '0;
            pk_clear <= 1'b0;
            pk_word <= 1'b0;
            ctl_valid <= 1'b0;
            echo_wr <= 1'b0;
            clksel <= '0;
            slot_restart <= '0;
            rpt_start <= 1'b0;
            rpt_code <= DIRCHAN_REPORT;
            rpt_slot <= '0;
            rpt_count <= '0;
        end else begin
            pk_clear <= 1'b0;
            pk_word <= 1'b0;
            ctl_valid <= 1'b0;
            echo_wr <= 1'b0;
            slot_restart <= '0;
            rpt_start <= 1'b0;
            if (in_valid) begin
                case (state)
                    ST_SLOT: begin
                        slot <= in_data[7:0];
                        state <= ST_CMD;
                    end
                    ST_CMD: begin
                        cmd <= cmd_e'(in_data[7:0]);
                        word_cnt <= '0;
                        csum_calc <= '0;
                        case (cmd_e'(in_data[7:0]))
                            AUD_FIFO_WRITE, CMD_FIFO_WRITE: begin
                                pk_clear <= 1'b1;
                                state <= ST_BODY;
                            end
                            ECHO_SEND, SELECT_CLOCK: state <= ST_BODY;
                            DIRCHAN_READ, AOVF_READ: begin
                                rpt_start <= 1'b1;
                                rpt_code <= (in_data[7:0] == DIRCHAN_READ) ?
                                            DIRCHAN_REPORT : AOVF_REPORT;
                                rpt_slot <= GLOBAL_SLOT;
                                state <= ST_SLOT;
                            end
                            // Unknown command ends the frame here
                            default: state <= ST_SLOT;
                        endcase
                    end
                    ST_BODY: begin
                        word_cnt <= word_cnt + 25'd1;
                        case (cmd)
                            AUD_FIFO_WRITE, CMD_FIFO_WRITE: begin
                                if (word_cnt < 25'(LEN_WORDS)) begin
                                    length <= {length[7:0], in_data};
                                    if (word_cnt == 25'(LEN_WORDS - 1) &&
                                        {length[7:0], in_data} == 24'd0) begin
                                        word_cnt <= '0;
                                        state <= ST_CSUM;
                                    end
                                end else begin
                                    csum_calc <= csum_calc + checksum_t'(in_data);
                                    pk_word <= (cmd == AUD_FIFO_WRITE);
                                    ctl_valid <= (cmd == CMD_FIFO_WRITE);
                                    if (word_cnt == {1'b0, length} + 25'(LEN_WORDS - 1)) begin
                                        word_cnt <= '0;
                                        state <= ST_CSUM;
                                    end
                                end
                            end
                            ECHO_SEND: begin
                                if (word_cnt == '0) begin
                                    rpt_count <= (in_data > echo_max) ? echo_max : in_data;
                                end else begin
                                    echo_wr <= 1'b1;
                                    if (word_cnt == 25'(rpt_count)) begin
                                        rpt_start <= 1'b1;
                                        rpt_code <= ECHO_REPORT;
                                        rpt_slot <= slot;
                                        state <= ST_SLOT;
                                    end
                                end
                            end
                            SELECT_CLOCK: begin
                                // Restart every slot whose clock source moves
                                clksel <= in_data[num_slots-1:0];
                                slot_restart <= clksel ^ in_data[num_slots-1:0];
                                state <= ST_SLOT;
                            end
                            default: state <= ST_SLOT;
                        endcase
                    end
                    ST_CSUM: begin
                        word_cnt <= word_cnt + 25'd1;
                        csum_received <= {csum_received[15:0], in_data};
                        if (word_cnt == 25'(CSUM_WORDS - 1)) begin
                            state <= ST_SLOT;
                            if ({csum_received[15:0], in_data} != csum_calc) begin
                                rpt_start <= 1'b1;
                                rpt_code <= CHECKSUM_ERROR;
                                rpt_slot <= slot;
                            end
                        end
                    end
                    default: state <= ST_SLOT;
                endcase
            end
        end
    end

endmodule

//--- logic/da_reply_builder.sv
////////////////////////////////////////
// Reply builder, second pipeline stage
// Sends slot, report code and payload as
// back-to-back host words
////////////////////////////////////////

`timescale 1ns/1ps

module da_reply_builder (
    input  logic                    cr_core,
    input  logic                    arst_n,
    input  logic                    rpt_start,
    input  da_host_pkg::rpt_e       rpt_code,
    input  da_slot_pkg::slot_idx_t  rpt_slot,
    input  da_host_pkg::host_word_t rpt_count,
    input  da_host_pkg::checksum_t  csum_received,
    input  da_host_pkg::checksum_t  csum_calc,
    input  da_slot_pkg::status_t    dirchan,
    input  da_slot_pkg::status_t    aovf,
    output logic                    echo_rd,
    input  da_host_pkg::host_word_t echo_data,
    output logic                    out_valid,
    output da_host_pkg::host_word_t out_data
);
    import da_host_pkg::*;

    logic       busy;
    rpt_e       code_q;
    host_word_t count_q;
    // Index of the next word to send, slot word is index 0
    host_word_t idx;
    host_word_t last_idx;
    host_word_t next_word;

    // Checksums stay put in the parser until the next command word
    always_comb begin
        next_word = '0;
        case (code_q)
            DIRCHAN_REPORT: next_word = host_word_t'(dirchan);
            AOVF_REPORT:    next_word = host_word_t'(aovf);
            ECHO_REPORT:    next_word = (idx == 16'd2) ? count_q : echo_data;
            CHECKSUM_ERROR: begin
                case (idx)
                    16'd2:   next_word = csum_received[31:16];
                    16'd3:   next_word = csum_received[15:0];
                    16'd4:   next_word = csum_calc[31:16];
                    default: next_word = csum_calc[15:0];
                endcase
            end
            default: next_word = '0;
        endcase
        if (idx == 16'd1)
            next_word = host_word_t'(code_q);
    end

    // Echo words follow the count word
    assign echo_rd = busy && (code_q == ECHO_REPORT) && (idx > 16'd2);

    always_ff @(posedge cr_core or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            code_q <= DIRCHAN_REPORT;
            count_q <= '0;
            idx <= '0;
            last_idx <= '0;
            out_valid <= 1'b0;
            out_data <= '0;
        end else begin
            out_valid <= 1'b0;
            if (rpt_start) begin
                busy <= 1'b1;
                code_q <= rpt_code;
                count_q <= rpt_count;
                idx <= 16'd1;
                out_valid <= 1'b1;
                out_data <= host_word_t'(rpt_slot);
                case (rpt_code)
                    ECHO_REPORT:    last_idx <= rpt_count + 16'd2;
                    CHECKSUM_ERROR: last_idx <= 16'd5;
                    default:        last_idx <= 16'd2;
                endcase
            end else if (busy) begin
                out_valid <= 1'b1;
                out_data <= next_word;
                idx <= idx + 16'd1;
                if (idx == last_idx)
                    busy <= 1'b0;
            end
        end
    end

    a_no_overlap: assert property (@(posedge cr_core) disable iff (!arst_n)
        rpt_start |-> !busy);

endmodule

//--- logic/da_host_core.sv
////////////////////////////////////////
// Host command core top level
// Parser, sample packer, echo FIFO and
// reply builder
////////////////////////////////////////

`timescale 1ns/1ps

module da_host_core #(
    parameter int num_slots = 4,
    parameter int echo_log_depth = 4
) (
    input  logic                    cr_core,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  da_host_pkg::host_word_t in_data,
    input  da_slot_pkg::status_t    dirchan,
    input  da_slot_pkg::status_t    aovf,
    output logic                    out_valid,
    output da_host_pkg::host_word_t out_data,
    output logic                    sample_valid,
    output da_slot_pkg::sample_t    sample_data,
    output da_slot_pkg::slot_idx_t  sample_slot,
    output logic                    ctl_valid,
    output da_slot_pkg::slot_idx_t  ctl_slot,
    output da_slot_pkg::ctl_byte_t  ctl_data,
    output logic [num_slots-1:0]    clksel,
    output logic [num_slots-1:0]    slot_restart
);
    import da_host_pkg::*;

    logic       pk_clear;
    logic       pk_word;
    host_word_t pk_data;
    logic       echo_wr;
    host_word_t echo_wr_data;
    logic       echo_rd;
    host_word_t echo_rd_data;
    logic       echo_empty;
    logic       rpt_start;
    rpt_e       rpt_code;
    logic [7:0] rpt_slot;
    host_word_t rpt_count;
    checksum_t  csum_received;
    checksum_t  csum_calc;

    // The addressed slot tags both samples and control bytes
    da_cmd_parser #(
        .num_slots      (num_slots),
        .echo_log_depth (echo_log_depth)
    ) parser0 (
        .cr_core, .arst_n, .in_valid, .in_data,
        .pk_clear, .pk_word, .pk_data,
        .slot          (ctl_slot),
        .ctl_valid, .ctl_data,
        .echo_wr,
        .echo_data     (echo_wr_data),
        .clksel, .slot_restart,
        .rpt_start, .rpt_code, .rpt_slot, .rpt_count,
        .csum_received, .csum_calc
    );

    da_sample_packer packer0 (
        .cr_core, .arst_n, .pk_clear, .pk_word, .pk_data,
        .pk_slot       (ctl_slot),
        .sample_valid, .sample_data, .sample_slot
    );

    da_echo_fifo #(
        .echo_log_depth (echo_log_depth)
    ) echo0 (
        .cr_core, .arst_n,
        .wr_valid      (echo_wr),
        .wr_data       (echo_wr_data),
        .rd_ready      (echo_rd),
        .rd_data       (echo_rd_data),
        .empty         (echo_empty)
    );

    da_reply_builder builder0 (
        .cr_core, .arst_n,
        .rpt_start, .rpt_code, .rpt_slot, .rpt_count,
        .csum_received, .csum_calc, .dirchan, .aovf,
        .echo_rd,
        .echo_data     (echo_rd_data),
        .out_valid, .out_data
    );

    // Every buffered echo word has gone out by the end of a reply
    a_echo_drained: assert property (@(posedge cr_core) disable iff (!arst_n)
        $fell(out_valid) |-> echo_empty);

endmodule

//--- verification/da_tb_clock.sv
////////////////////////////////////////
// Testbench clock and reset source
// 20 ns core clock, reset low 8 cycles
////////////////////////////////////////

`timescale 1ns/1ps

module da_tb_clock #(
    parameter int half_period = 10,
    parameter int reset_cycles = 8
) (
    output logic cr_core,
    output logic arst_n
);

    initial begin
        cr_core = 1'b0;
        forever #(half_period) cr_core = ~cr_core;
    end

    // Release away from the clock edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge cr_core);
        #2;
        arst_n = 1'b1;
    end

endmodule

//--- verification/da_host_core_tb.sv
////////////////////////////////////////
// Testbench for the host command core
// Applies a table of frames and checks
// replies, samples, control and clocks
////////////////////////////////////////

`timescale 1ns/1ps

module da_host_core_tb;
    import da_host_pkg::*;
    import da_slot_pkg::*;

    localparam int num_slots = 4;
    localparam int echo_log_depth = 4;
    localparam status_t dirchan_val = 8'h5a;
    localparam status_t aovf_val = 8'hc3;

    logic                 cr_core;
    logic                 arst_n;
    logic                 in_valid;
    host_word_t           in_data;
    status_t              dirchan;
    status_t              aovf;
    logic                 out_valid;
    host_word_t           out_data;
    logic                 sample_valid;
    sample_t              sample_data;
    slot_idx_t            sample_slot;
    logic                 ctl_valid;
    slot_idx_t            ctl_slot;
    ctl_byte_t            ctl_data;
    logic [num_slots-1:0] clksel;
    logic [num_slots-1:0] slot_restart;

    // Frame table as flat word queues with per frame counts
    host_word_t stim_q[$];
    host_word_t payload_q[$];
    int         frame_len[$];
    int         frame_rpl[$];
    int         frame_smp[$];
    int         frame_ctl[$];
    int         frame_clk[$];
    bit         frame_lat[$];

    // Expected results in order of arrival
    host_word_t           exp_out[$];
    sample_t              exp_smp[$];
    slot_idx_t            exp_smp_slot[$];
    ctl_byte_t            exp_ctl[$];
    slot_idx_t            exp_ctl_slot[$];
    logic [num_slots-1:0] exp_clksel[$];
    logic [num_slots-1:0] exp_restart[$];

    // Observed at the DUT outputs
    host_word_t           obs_out[$];
    int                   obs_out_cyc[$];
    sample_t              obs_smp[$];
    slot_idx_t            obs_smp_slot[$];
    ctl_byte_t            obs_ctl[$];
    slot_idx_t            obs_ctl_slot[$];
    logic [num_slots-1:0] obs_clksel[$];
    logic [num_slots-1:0] obs_restart[$];

    int                   cyc = 0;
    int                   cyc_limit = 0;
    int                   last_in_cyc = 0;
    int                   errors = 0;
    int                   checks = 0;
    logic [31:0]          lcg_state = 32'hee4e;

    da_tb_clock clock0 (
        .cr_core (cr_core),
        .arst_n  (arst_n)
    );

    da_host_core #(
        .num_slots      (num_slots),
        .echo_log_depth (echo_log_depth)
    ) dut0 (
        .cr_core, .arst_n, .in_valid, .in_data, .dirchan, .aovf,
        .out_valid, .out_data, .sample_valid, .sample_data, .sample_slot,
        .ctl_valid, .ctl_slot, .ctl_data, .clksel, .slot_restart
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_word(string name, host_word_t got, host_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_sample(string name, sample_t got, sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ctl(string name, ctl_byte_t got, ctl_byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_slot(string name, slot_idx_t got, slot_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_clk(string name, logic [num_slots-1:0] got,
                             logic [num_slots-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(int f, string what, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Frame %0d gave %0d %s where %0d were expected", f, got, what, exp);
        end
    endtask

    task automatic push_frame(int len, int rpl, int smp, int ctl, int clk, bit lat);
        frame_len.push_back(len);
        frame_rpl.push_back(rpl);
        frame_smp.push_back(smp);
        frame_ctl.push_back(ctl);
        frame_clk.push_back(clk);
        frame_lat.push_back(lat);
    endtask

    // FIFO write of payload_q with a bad checksum on request
    task automatic add_fifo_write(slot_idx_t s, cmd_e c, bit corrupt);
        checksum_t   sum;
        checksum_t   sent;
        logic [23:0] len;
        int          n;
        int          smp;
        sum = '0;
        n = payload_q.size();
        len = 24'(n);
        smp = 0;
        stim_q.push_back({8'h00, s});
        stim_q.push_back({8'h00, c});
        stim_q.push_back({8'h00, len[23:16]});
        stim_q.push_back(len[15:0]);
        foreach (payload_q[i]) begin
            stim_q.push_back(payload_q[i]);
            sum = sum + checksum_t'(payload_q[i]);
            if (c == CMD_FIFO_WRITE) begin
                exp_ctl.push_back(payload_q[i][7:0]);
                exp_ctl_slot.push_back(s);
            end
        end
        // First word of a pair is the high half and a lone last word is lost
        for (int i = 0; c == AUD_FIFO_WRITE && i + 1 < n; i += 2) begin
            exp_smp.push_back({payload_q[i], payload_q[i+1]});
            exp_smp_slot.push_back(s);
            smp++;
        end
        sent = corrupt ? sum + (lcg_next() | 32'd1) : sum;
        stim_q.push_back(sent[31:16]);
        stim_q.push_back(sent[15:0]);
        if (corrupt) begin
            exp_out.push_back({8'h00, s});
            exp_out.push_back({8'h00, CHECKSUM_ERROR});
            exp_out.push_back(sent[31:16]);
            exp_out.push_back(sent[15:0]);
            exp_out.push_back(sum[31:16]);
            exp_out.push_back(sum[15:0]);
        end
        push_frame(n + 6, corrupt ? 6 : 0, smp, (c == CMD_FIFO_WRITE) ? n : 0, 0, 1'b0);
    endtask

    task automatic add_echo(slot_idx_t s, int n);
        logic [31:0] r;
        stim_q.push_back({8'h00, s});
        stim_q.push_back({8'h00, ECHO_SEND});
        stim_q.push_back(host_word_t'(n));
        exp_out.push_back({8'h00, s});
        exp_out.push_back({8'h00, ECHO_REPORT});
        exp_out.push_back(host_word_t'(n));
        for (int i = 0; i < n; i++) begin
            r = lcg_next();
            stim_q.push_back(r[31:16]);
            exp_out.push_back(r[31:16]);
        end
        push_frame(n + 3, n + 3, 0, 0, 0, 1'b0);
    endtask

    task automatic add_status_read(cmd_e c);
        stim_q.push_back(16'h0000);
        stim_q.push_back({8'h00, c});
        exp_out.push_back({8'h00, GLOBAL_SLOT});
        if (c == DIRCHAN_READ) begin
            exp_out.push_back({8'h00, DIRCHAN_REPORT});
            exp_out.push_back({8'h00, dirchan_val});
        end else begin
            exp_out.push_back({8'h00, AOVF_REPORT});
            exp_out.push_back({8'h00, aovf_val});
        end
        push_frame(2, 3, 0, 0, 0, 1'b1);
    endtask

    // A selection that moves no slot gives no restart pulse
    task automatic add_select_clock(logic [num_slots-1:0] sel,
                                    logic [num_slots-1:0] restart);
        stim_q.push_back(16'h0000);
        stim_q.push_back({8'h00, SELECT_CLOCK});
        stim_q.push_back(host_word_t'(sel));
        if (restart != '0) begin
            exp_clksel.push_back(sel);
            exp_restart.push_back(restart);
        end
        push_frame(3, 0, 0, 0, (restart != '0) ? 1 : 0, 1'b0);
    endtask

    task automatic check_frame(int f);
        check_count(f, "reply words", obs_out.size(), frame_rpl[f]);
        for (int i = 0; i < frame_rpl[f]; i++) begin
            if (i < obs_out.size())
                check_word("out_data", obs_out[i], exp_out[0]);
            void'(exp_out.pop_front());
        end
        if (frame_lat[f] && obs_out_cyc.size() > 0 && obs_out_cyc[0] - last_in_cyc != 2) begin
            errors++;
            $display("Frame %0d reply started %0d cycles after its last word instead of 2",
                     f, obs_out_cyc[0] - last_in_cyc);
        end
        for (int i = 1; i < obs_out_cyc.size(); i++) begin
            if (obs_out_cyc[i] != obs_out_cyc[i-1] + 1) begin
                errors++;
                $display("Frame %0d reply has a gap before word %0d", f, i);
            end
        end
        check_count(f, "samples", obs_smp.size(), frame_smp[f]);
        for (int i = 0; i < frame_smp[f]; i++) begin
            if (i < obs_smp.size()) begin
                check_sample("sample_data", obs_smp[i], exp_smp[0]);
                check_slot("sample_slot", obs_smp_slot[i], exp_smp_slot[0]);
            end
            void'(exp_smp.pop_front());
            void'(exp_smp_slot.pop_front());
        end
        check_count(f, "control bytes", obs_ctl.size(), frame_ctl[f]);
        for (int i = 0; i < frame_ctl[f]; i++) begin
            if (i < obs_ctl.size()) begin
                check_ctl("ctl_data", obs_ctl[i], exp_ctl[0]);
                check_slot("ctl_slot", obs_ctl_slot[i], exp_ctl_slot[0]);
            end
            void'(exp_ctl.pop_front());
            void'(exp_ctl_slot.pop_front());
        end
        check_count(f, "restart pulses", obs_restart.size(), frame_clk[f]);
        for (int i = 0; i < frame_clk[f]; i++) begin
            if (i < obs_restart.size()) begin
                check_clk("clksel", obs_clksel[i], exp_clksel[0]);
                check_clk("slot_restart", obs_restart[i], exp_restart[0]);
            end
            void'(exp_clksel.pop_front());
            void'(exp_restart.pop_front());
        end
        obs_out.delete();
        obs_out_cyc.delete();
        obs_smp.delete();
        obs_smp_slot.delete();
        obs_ctl.delete();
        obs_ctl_slot.delete();
        obs_clksel.delete();
        obs_restart.delete();
    endtask

    // Outputs are stable at the falling edge
    always @(negedge cr_core) begin
        if (arst_n) begin
            if (in_valid)
                last_in_cyc = cyc;
            if (out_valid) begin
                obs_out.push_back(out_data);
                obs_out_cyc.push_back(cyc);
            end
            if (sample_valid) begin
                obs_smp.push_back(sample_data);
                obs_smp_slot.push_back(sample_slot);
            end
            if (ctl_valid) begin
                obs_ctl.push_back(ctl_data);
                obs_ctl_slot.push_back(ctl_slot);
            end
            if (slot_restart != '0) begin
                obs_clksel.push_back(clksel);
                obs_restart.push_back(slot_restart);
            end
        end
    end

    always @(posedge cr_core) begin
        cyc = cyc + 1;
        if (cyc_limit > 0 && cyc > cyc_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cyc);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int k;
        in_valid = 1'b0;
        in_data = '0;
        dirchan = dirchan_val;
        aovf = aovf_val;
        k = 0;

        payload_q = '{16'h1234, 16'h5678, 16'h9abc, 16'hdef0};
        add_fifo_write(8'd2, AUD_FIFO_WRITE, 1'b0);
        payload_q = '{16'h00a5, 16'h013c, 16'h0f07};
        add_fifo_write(8'd1, CMD_FIFO_WRITE, 1'b0);
        payload_q = '{16'h0f0f, 16'hf0f0, 16'h5555};
        add_fifo_write(8'd3, AUD_FIFO_WRITE, 1'b1);
        add_echo(8'd1, 5);
        add_status_read(DIRCHAN_READ);
        add_status_read(AOVF_READ);
        add_select_clock(4'b0101, 4'b0101);
        add_select_clock(4'b0110, 4'b0011);
        cyc_limit = 8 + stim_q.size() + 40 * frame_len.size();

        wait (arst_n === 1'b1);
        @(negedge cr_core);
        if (out_valid !== 1'b0 || sample_valid !== 1'b0 || ctl_valid !== 1'b0) begin
            errors++;
            $display("A strobe output is high right after reset");
        end
        check_clk("clksel", clksel, '0);
        check_clk("slot_restart", slot_restart, '0);

        for (int f = 0; f < frame_len.size(); f++) begin
            for (int i = 0; i < frame_len[f]; i++) begin
                @(posedge cr_core);
                #2;
                in_valid = 1'b1;
                in_data = stim_q[k];
                k++;
            end
            @(posedge cr_core);
            #2;
            in_valid = 1'b0;
            in_data = '0;
            while (obs_out.size() < frame_rpl[f])
                @(negedge cr_core);
            // Quiet cycles let late strobes or extra words show up
            repeat (4) @(negedge cr_core);
            check_frame(f);
        end

        $display("Run complete, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- da_host_core.f
logic/da_host_pkg.sv
logic/da_slot_pkg.sv
logic/da_sample_packer.sv
logic/da_echo_fifo.sv
logic/da_cmd_parser.sv
logic/da_reply_builder.sv
logic/da_host_core.sv
verification/da_tb_clock.sv
verification/da_host_core_tb.sv

//--- Makefile
SRCS = $(wildcard logic/*.sv verification/*.sv)

.PHONY: all run clean

all: obj_dir/Vda_host_core_tb

obj_dir/Vda_host_core_tb: da_host_core.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module da_host_core_tb -Mdir obj_dir -f da_host_core.f

run: obj_dir/Vda_host_core_tb
	./obj_dir/Vda_host_core_tb > sim.log
	cat sim.log
	grep -qxF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
